//--- sfifo.f
+incdir+verif
common/sfifo_cfg_pkg.sv
common/sfifo_types_pkg.sv
hw/sfifo/memory_array.sv
hw/sfifo/pointer_sync.sv
hw/sfifo/write_control.sv
hw/sfifo/read_control.sv
hw/sfifo/sfifo.sv
verif/tb_sfifo.sv

//--- Bender.yml
package:
  name: sfifo

sources:
  # Packages first, then the RTL in dependency order.
  - files:
      - common/sfifo_cfg_pkg.sv
      - common/sfifo_types_pkg.sv
      - hw/sfifo/memory_array.sv
      - hw/sfifo/pointer_sync.sv
      - hw/sfifo/write_control.sv
      - hw/sfifo/read_control.sv
      - hw/sfifo/sfifo.sv

  # Testbench top tb_sfifo.
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_sfifo.sv

//--- verif/tb_sfifo_checks.svh
// Testbench helpers for the FIFO: xorshift data, reference queue model and typed compare tasks.
`ifndef TB_SFIFO_CHECKS_SVH
`define TB_SFIFO_CHECKS_SVH

// ----------------------------------------------------------------------
// Stimulus data and reference model
// ----------------------------------------------------------------------
logic [31:0]                          rng_state = 32'h6ca;
logic [sfifo_cfg_pkg::data_width-1:0] model_q [$];
int                                   mismatch_count = 0;
int                                   failure_count = 0;

// 32-bit xorshift with the 13/17/5 shift triple.
function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

task automatic report_failure(input string msg);
    failure_count++;
    $display("Error at %0t: %s", $time, msg);
endtask

// ----------------------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------------------

// r_data only carries meaning in a cycle where read_ack is high.
task automatic check_rd_resp(input sfifo_types_pkg::rd_resp_t expected,
                             input sfifo_types_pkg::rd_resp_t actual);
    if (actual.read_ack !== expected.read_ack ||
        (expected.read_ack && actual.r_data !== expected.r_data)) begin
        mismatch_count++;
        $display("Mismatch at %0t: rd_resp expected ack=%b data=%h, actual ack=%b data=%h",
                 $time, expected.read_ack, expected.r_data, actual.read_ack, actual.r_data);
    end
endtask

// Bits are shown as write_ack, full, halffull.
task automatic check_wr_status(input sfifo_types_pkg::wr_status_t expected,
                               input sfifo_types_pkg::wr_status_t actual);
    if (actual !== expected) begin
        mismatch_count++;
        $display("Mismatch at %0t: wr_status expected %b actual %b", $time, expected, actual);
    end
endtask

// Bits are shown as empty, halfempty.
task automatic check_rd_status(input sfifo_types_pkg::rd_status_t expected,
                               input sfifo_types_pkg::rd_status_t actual);
    if (actual !== expected) begin
        mismatch_count++;
        $display("Mismatch at %0t: rd_status expected %b actual %b", $time, expected, actual);
    end
endtask

`endif

//--- verif/tb_sfifo.sv
// Testbench for the two-clock FIFO with directed tests against a queue model.
`timescale 1ns/100ps

module tb_sfifo;

    localparam int timeout_cycles = 3000;
    localparam int wait_limit     = 20;

    logic                        clk_write_logic;
    logic                        clk_read_logic;
    logic                        rst_n;
    sfifo_types_pkg::wr_req_t    wr_req;
    sfifo_types_pkg::wr_status_t wr_status;
    logic                        read_request;
    sfifo_types_pkg::rd_resp_t   rd_resp;
    sfifo_types_pkg::rd_status_t rd_status;
    int                          cycle_count;

    `include "tb_sfifo_checks.svh"

    sfifo dut_i (
        .clk_write_logic (clk_write_logic),
        .clk_read_logic  (clk_read_logic),
        .rst_n           (rst_n),
        .wr_req          (wr_req),
        .wr_status       (wr_status),
        .read_request    (read_request),
        .rd_resp         (rd_resp),
        .rd_status       (rd_status)
    );

    initial begin
        clk_write_logic = 1'b0;
        forever #20 clk_write_logic = ~clk_write_logic;
    end

    initial begin
        clk_read_logic = 1'b0;
        forever #28 clk_read_logic = ~clk_read_logic;
    end

    // ------------------------------------------------------------------
    // Handshake helpers
    // ------------------------------------------------------------------

    // Flags are sampled on the falling edge, where they are stable for the next rising edge.
    task automatic write_word(input logic [sfifo_cfg_pkg::data_width-1:0] data);
        int   waited;
        logic blocked;
        waited = 0;
        @(posedge clk_write_logic);
        wr_req <= '{write_request: 1'b1, w_data: data};
        @(negedge clk_write_logic);
        blocked = wr_status.full;
        while (blocked && waited < wait_limit) begin
            @(negedge clk_write_logic);
            blocked = wr_status.full;
            waited++;
        end
        @(posedge clk_write_logic);
        wr_req.write_request <= 1'b0;
        if (blocked) begin
            report_failure("write request stayed blocked by full for more than 20 cycles");
        end else begin
            @(negedge clk_write_logic);
            if (wr_status.write_ack !== 1'b1) begin
                mismatch_count++;
                $display("Mismatch at %0t: wr_status.write_ack expected 1 actual %b",
                         $time, wr_status.write_ack);
            end else begin
                model_q.push_back(data);
            end
        end
    endtask

    task automatic read_word();
        sfifo_types_pkg::rd_resp_t expected;
        int                        waited;
        logic                      blocked;
        waited = 0;
        @(posedge clk_read_logic);
        read_request <= 1'b1;
        @(negedge clk_read_logic);
        blocked = rd_status.empty;
        while (blocked && waited < wait_limit) begin
            @(negedge clk_read_logic);
            blocked = rd_status.empty;
            waited++;
        end
        @(posedge clk_read_logic);
        read_request <= 1'b0;
        if (blocked) begin
            report_failure("read request saw empty for more than 20 read cycles");
        end else if (model_q.size() == 0) begin
            report_failure("read accepted while the model holds no word");
        end else begin
            expected = '{read_ack: 1'b1, r_data: model_q.pop_front()};
            @(negedge clk_read_logic);
            check_rd_resp(expected, rd_resp);
        end
    endtask

    task automatic wait_rd_status(input sfifo_types_pkg::rd_status_t expected);
        int waited;
        waited = 0;
        @(negedge clk_read_logic);
        while (rd_status !== expected && waited < wait_limit) begin
            @(negedge clk_read_logic);
            waited++;
        end
        if (rd_status !== expected) begin
            report_failure("rd_status did not settle within 20 read cycles");
        end
        check_rd_status(expected, rd_status);
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic test_reset_state();
        @(negedge clk_write_logic);
        check_wr_status('{write_ack: 1'b0, full: 1'b0, halffull: 1'b0}, wr_status);
        @(negedge clk_read_logic);
        check_rd_status('{empty: 1'b1, halfempty: 1'b1}, rd_status);
        check_rd_resp('{read_ack: 1'b0, r_data: '0}, rd_resp);
    endtask

    task automatic test_ordered_transfer();
        repeat (10) write_word(next_random());
        repeat (10) read_word();
    endtask

    task automatic test_fill_to_full();
        for (int count = 1; count <= sfifo_cfg_pkg::fifo_depth; count++) begin
            write_word(next_random());
            if (count >= 60) begin
                check_wr_status('{write_ack: 1'b1, full: (count == sfifo_cfg_pkg::fifo_depth),
                                  halffull: 1'b1}, wr_status);
            end
        end
        // One more request while full must go unacknowledged.
        @(posedge clk_write_logic);
        wr_req <= '{write_request: 1'b1, w_data: next_random()};
        repeat (5) begin
            @(negedge clk_write_logic);
            check_wr_status('{write_ack: 1'b0, full: 1'b1, halffull: 1'b1}, wr_status);
        end
        @(posedge clk_write_logic);
        wr_req.write_request <= 1'b0;
    endtask

    task automatic test_read_on_empty();
        repeat (sfifo_cfg_pkg::fifo_depth) read_word();
        wait_rd_status('{empty: 1'b1, halfempty: 1'b1});
        @(posedge clk_read_logic);
        read_request <= 1'b1;
        repeat (5) begin
            @(negedge clk_read_logic);
            check_rd_resp('{read_ack: 1'b0, r_data: '0}, rd_resp);
        end
        @(posedge clk_read_logic);
        read_request <= 1'b0;
    endtask

    task automatic test_threshold_flags();
        repeat (6) write_word(next_random());
        wait_rd_status('{empty: 1'b0, halfempty: 1'b0});
        repeat (2) read_word();
        wait_rd_status('{empty: 1'b0, halfempty: 1'b1});
        repeat (4) read_word();
        wait_rd_status('{empty: 1'b1, halfempty: 1'b1});
    endtask

    task automatic test_wrap_concurrency();
        fork
            repeat (150) write_word(next_random());
            repeat (150) read_word();
        join
        wait_rd_status('{empty: 1'b1, halfempty: 1'b1});
        if (model_q.size() != 0) begin
            report_failure("model still holds words after the concurrent test");
        end
    endtask

    // ------------------------------------------------------------------
    // Run control
    // ------------------------------------------------------------------
    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk_write_logic);
            cycle_count++;
        end
        $display("Timeout: the run exceeded %0d write clock cycles", timeout_cycles);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        wr_req       = '0;
        read_request = 1'b0;
        rst_n        = 1'b0;
        repeat (3) @(posedge clk_write_logic);
        rst_n <= 1'b1;
        test_reset_state();
        test_ordered_transfer();
        test_fill_to_full();
        test_read_on_empty();
        test_threshold_flags();
        test_wrap_concurrency();
        $display("Summary: %0d mismatches, %0d other errors", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- hw/sfifo/sfifo.sv
// Two-clock FIFO top level joining the controllers, the pointer synchronizers and the storage.
`timescale 1ns/100ps

module sfifo (
    input  logic                         clk_write_logic,
    input  logic                         clk_read_logic,
    input  logic                         rst_n,
    input  sfifo_types_pkg::wr_req_t     wr_req,
    output sfifo_types_pkg::wr_status_t  wr_status,
    input  logic                         read_request,
    output sfifo_types_pkg::rd_resp_t    rd_resp,
    output sfifo_types_pkg::rd_status_t  rd_status
);

    logic                                  w_enable;
    logic                                  r_enable;
    logic [sfifo_cfg_pkg::addr_width-1:0]  w_addr;
    logic [sfifo_cfg_pkg::addr_width-1:0]  r_addr;
    logic [sfifo_cfg_pkg::ptr_width-1:0]   wr_ptr_gray;
    logic [sfifo_cfg_pkg::ptr_width-1:0]   wr_ptr_gray_sync;
    logic [sfifo_cfg_pkg::ptr_width-1:0]   rd_ptr_gray;
    logic [sfifo_cfg_pkg::ptr_width-1:0]   rd_ptr_gray_sync;
    logic                                  read_ack;
    logic [sfifo_cfg_pkg::data_width-1:0]  r_data;

    assign rd_resp = '{read_ack: read_ack, r_data: r_data};

    // ------------------------------------------------------------------
    // Write clock domain
    // ------------------------------------------------------------------
    write_control write_control_i (
        .clk_write_logic  (clk_write_logic),
        .rst_n            (rst_n),
        .wr_req           (wr_req),
        .rd_ptr_gray_sync (rd_ptr_gray_sync),
        .w_enable         (w_enable),
        .w_addr           (w_addr),
        .wr_ptr_gray      (wr_ptr_gray),
        .wr_status        (wr_status)
    );

    // The read pointer enters the write domain here.
    pointer_sync rd_sync_i (
        .clk           (clk_write_logic),
        .rst_n         (rst_n),
        .ptr_gray      (rd_ptr_gray),
        .ptr_gray_sync (rd_ptr_gray_sync)
    );

    // ------------------------------------------------------------------
    // Read clock domain
    // ------------------------------------------------------------------
    read_control read_control_i (
        .clk_read_logic   (clk_read_logic),
        .rst_n            (rst_n),
        .read_request     (read_request),
        .wr_ptr_gray_sync (wr_ptr_gray_sync),
        .r_enable         (r_enable),
        .r_addr           (r_addr),
        .rd_ptr_gray      (rd_ptr_gray),
        .read_ack         (read_ack),
        .rd_status        (rd_status)
    );

    pointer_sync wr_sync_i (
        .clk           (clk_read_logic),
        .rst_n         (rst_n),
        .ptr_gray      (wr_ptr_gray),
        .ptr_gray_sync (wr_ptr_gray_sync)
    );

    memory_array memory_array_i (
        .clk_write_logic (clk_write_logic),
        .clk_read_logic  (clk_read_logic),
        .w_enable        (w_enable),
        .w_addr          (w_addr),
        .w_data          (wr_req.w_data),
        .r_enable        (r_enable),
        .r_addr          (r_addr),
        .r_data          (r_data)
    );

endmodule

//--- hw/sfifo/read_control.sv
// Read side controller holding the read pointer, the read handshake and the empty flags.
`timescale 1ns/100ps

module read_control (
    input  logic                                 clk_read_logic,
    input  logic                                 rst_n,
    input  logic                                 read_request,
    input  logic [sfifo_cfg_pkg::ptr_width-1:0]  wr_ptr_gray_sync,
    output logic                                 r_enable,
    output logic [sfifo_cfg_pkg::addr_width-1:0] r_addr,
    output logic [sfifo_cfg_pkg::ptr_width-1:0]  rd_ptr_gray,
    output logic                                 read_ack,
    output sfifo_types_pkg::rd_status_t          rd_status
);

    logic [sfifo_cfg_pkg::ptr_width-1:0] rd_ptr;
    logic [sfifo_cfg_pkg::ptr_width-1:0] rd_ptr_next;
    logic [sfifo_cfg_pkg::ptr_width-1:0] wr_ptr_bin;
    logic [sfifo_cfg_pkg::ptr_width-1:0] occupancy;
    logic                                empty;
    logic                                halfempty;

    // ------------------------------------------------------------------
    // Occupancy and flags
    // ------------------------------------------------------------------

    // A write shows up here only after the synchronizer, so the flags
    // err toward empty.
    assign wr_ptr_bin = sfifo_cfg_pkg::gray_to_ptr(wr_ptr_gray_sync);
    assign occupancy  = wr_ptr_bin - rd_ptr;

    assign empty     = (occupancy == '0);
    assign halfempty = (occupancy <= sfifo_cfg_pkg::halfempty_level);

    // ------------------------------------------------------------------
    // Read acceptance
    // ------------------------------------------------------------------
    assign r_enable    = read_request & ~empty;
    assign rd_ptr_next = rd_ptr + 1'b1;
    assign r_addr      = rd_ptr[sfifo_cfg_pkg::addr_width-1:0];

    // read_ack lines up with the word that the memory registers on r_enable.
    always_ff @(posedge clk_read_logic or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr      <= '0;
            rd_ptr_gray <= '0;
            read_ack    <= 1'b0;
        end else begin
            read_ack <= r_enable;
            if (r_enable) begin
                rd_ptr      <= rd_ptr_next;
                rd_ptr_gray <= sfifo_cfg_pkg::ptr_to_gray(rd_ptr_next);
            end
        end
    end

    assign rd_status = '{empty: empty, halfempty: halfempty};

    // The writer never laps the reader by more than the depth.
    a_occupancy_range: assert property (
        @(posedge clk_read_logic) disable iff (!rst_n)
        occupancy <= sfifo_cfg_pkg::fifo_depth
    );

endmodule

//--- hw/sfifo/write_control.sv
// Write side controller holding the write pointer, the write handshake and the full flags.
`timescale 1ns/100ps

module write_control (
    input  logic                                 clk_write_logic,
    input  logic                                 rst_n,
    input  sfifo_types_pkg::wr_req_t             wr_req,
    input  logic [sfifo_cfg_pkg::ptr_width-1:0]  rd_ptr_gray_sync,
    output logic                                 w_enable,
    output logic [sfifo_cfg_pkg::addr_width-1:0] w_addr,
    output logic [sfifo_cfg_pkg::ptr_width-1:0]  wr_ptr_gray,
    output sfifo_types_pkg::wr_status_t          wr_status
);

    logic [sfifo_cfg_pkg::ptr_width-1:0] wr_ptr;
    logic [sfifo_cfg_pkg::ptr_width-1:0] wr_ptr_next;
    logic [sfifo_cfg_pkg::ptr_width-1:0] rd_ptr_bin;
    logic [sfifo_cfg_pkg::ptr_width-1:0] occupancy;
    logic                                full;
    logic                                halffull;
    logic                                write_ack;

    // ------------------------------------------------------------------
    // Occupancy and flags
    // ------------------------------------------------------------------

    // The synchronized read pointer lags the real one, so the flags err
    // toward full.
    assign rd_ptr_bin = sfifo_cfg_pkg::gray_to_ptr(rd_ptr_gray_sync);
    assign occupancy  = wr_ptr - rd_ptr_bin;

    assign full     = (occupancy == sfifo_cfg_pkg::fifo_depth);
    assign halffull = (occupancy >= sfifo_cfg_pkg::fifo_depth - sfifo_cfg_pkg::halffull_level);

    // ------------------------------------------------------------------
    // Write acceptance
    // ------------------------------------------------------------------
    assign w_enable    = wr_req.write_request & ~full;
    assign wr_ptr_next = wr_ptr + 1'b1;
    assign w_addr      = wr_ptr[sfifo_cfg_pkg::addr_width-1:0];

    // The Gray copy is registered so that it leaves the domain glitch free.
    always_ff @(posedge clk_write_logic or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            wr_ptr_gray <= '0;
            write_ack   <= 1'b0;
        end else begin
            write_ack <= w_enable;
            if (w_enable) begin
                wr_ptr      <= wr_ptr_next;
                wr_ptr_gray <= sfifo_cfg_pkg::ptr_to_gray(wr_ptr_next);
            end
        end
    end

    assign wr_status = '{write_ack: write_ack, full: full, halffull: halffull};

    // The reader never overtakes the writer, so occupancy stays in range.
    a_occupancy_range: assert property (
        @(posedge clk_write_logic) disable iff (!rst_n)
        occupancy <= sfifo_cfg_pkg::fifo_depth
    );

endmodule

//--- hw/sfifo/pointer_sync.sv
// Two-flop synchronizer that carries a Gray-coded FIFO pointer into another clock domain.
`timescale 1ns/100ps

module pointer_sync (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [sfifo_cfg_pkg::ptr_width-1:0] ptr_gray,
    output logic [sfifo_cfg_pkg::ptr_width-1:0] ptr_gray_sync
);

    logic [sfifo_cfg_pkg::ptr_width-1:0] sync_q1;
    logic [sfifo_cfg_pkg::ptr_width-1:0] sync_step;

    // ------------------------------------------------------------------
    // Synchronizer stages
    // ------------------------------------------------------------------

    // The first stage may go metastable. Only one bit of the Gray code
    // moves per source update, so a late sample resolves to either the
    // old or the new pointer.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1       <= '0;
            ptr_gray_sync <= '0;
        end else begin
            sync_q1       <= ptr_gray;
            ptr_gray_sync <= sync_q1;
        end
    end

    // Distance the output moves on the next edge, in pointer steps.
    assign sync_step = sfifo_cfg_pkg::gray_to_ptr(sync_q1)
                     - sfifo_cfg_pkg::gray_to_ptr(ptr_gray_sync);

    // A faster source may step several times between samples, but the
    // pointer only moves forward and never by more than the FIFO depth.
    // A torn Gray sample would show up as a backward or oversized jump.
    a_pointer_forward: assert property (
        @(posedge clk) disable iff (!rst_n)
        sync_step <= sfifo_cfg_pkg::fifo_depth
    );

endmodule

//--- hw/sfifo/memory_array.sv
// Dual-clock storage of the FIFO words with a write port and a registered read port.
`timescale 1ns/100ps

module memory_array (
    input  logic                                 clk_write_logic,
    input  logic                                 clk_read_logic,
    input  logic                                 w_enable,
    input  logic [sfifo_cfg_pkg::addr_width-1:0] w_addr,
    input  logic [sfifo_cfg_pkg::data_width-1:0] w_data,
    input  logic                                 r_enable,
    input  logic [sfifo_cfg_pkg::addr_width-1:0] r_addr,
    output logic [sfifo_cfg_pkg::data_width-1:0] r_data
);

    logic [sfifo_cfg_pkg::data_width-1:0] mem [sfifo_cfg_pkg::fifo_depth];

    // ------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------
    always_ff @(posedge clk_write_logic) begin
        if (w_enable) begin
            mem[w_addr] <= w_data;
        end
    end

    // ------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------

    // The word appears on r_data one read cycle after r_enable and holds
    // until the next accepted read.
    always_ff @(posedge clk_read_logic) begin
        if (r_enable) begin
            r_data <= mem[r_addr];
        end
    end

endmodule

//--- common/sfifo_types_pkg.sv
// Grouped signal types for the write request, read response and status flags of the FIFO.
package sfifo_types_pkg;

    // ------------------------------------------------------------------
    // Write domain
    // ------------------------------------------------------------------

    // Write request from the producer together with its data word.
    typedef struct packed {
        logic                                  write_request;
        logic [sfifo_cfg_pkg::data_width-1:0]  w_data;
    } wr_req_t;

    // Write side status. The ack lasts one cycle after an accepted write.
    typedef struct packed {
        logic write_ack;
        logic full;
        logic halffull;
    } wr_status_t;

    // ------------------------------------------------------------------
    // Read domain
    // ------------------------------------------------------------------

    // Read response. r_data is valid in the cycle that read_ack is high.
    typedef struct packed {
        logic                                  read_ack;
        logic [sfifo_cfg_pkg::data_width-1:0]  r_data;
    } rd_resp_t;

    // Read side status flags.
    typedef struct packed {
        logic empty;
        logic halfempty;
    } rd_status_t;

endpackage

//--- common/sfifo_cfg_pkg.sv
// Size and threshold constants of the dual-clock FIFO, with the Gray coding of its pointers.
package sfifo_cfg_pkg;

    // ------------------------------------------------------------------
    // Storage geometry
    // ------------------------------------------------------------------

    // Number of words held by the FIFO.
    localparam int unsigned fifo_depth = 64;

    // Memory address width, log2 of the depth.
    localparam int unsigned addr_width = 6;

    // Width of one stored word.
    localparam int unsigned data_width = 16;

    // Pointers carry one extra wrap bit to tell full from empty.
    localparam int unsigned ptr_width = addr_width + 1;

    // ------------------------------------------------------------------
    // Status thresholds
    // ------------------------------------------------------------------

    // Halfempty stays high while occupancy is at most this many words.
    localparam int unsigned halfempty_level = 4;

    // Halffull stays high while free space is at most this many words.
    localparam int unsigned halffull_level = 4;

    // Binary to Gray conversion for a pointer that crosses clock domains.
    function automatic logic [ptr_width-1:0] ptr_to_gray(input logic [ptr_width-1:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    // Gray to binary conversion, folding from the top bit down.
    function automatic logic [ptr_width-1:0] gray_to_ptr(input logic [ptr_width-1:0] gray);
        logic [ptr_width-1:0] bin;
        bin[ptr_width-1] = gray[ptr_width-1];
        for (int i = ptr_width - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage
